/* design/tlb_pkg.sv */
// TLB shared definitions: page geometry, configuration register map and response codes
package tlb_pkg;

  // Low address bits passed through untranslated (4 KiB pages)
  localparam int unsigned PageOffsetWidth = 12;

  // Payload width of the request and response data
  localparam int unsigned DataWidth = 32;

  // Each entry owns a block of four configuration registers
  localparam int unsigned CfgRegsPerEntry = 4;
  localparam int unsigned CfgFirstReg     = 0;
  localparam int unsigned CfgLastReg      = 1;
  localparam int unsigned CfgBaseReg      = 2;
  localparam int unsigned CfgFlagsReg     = 3;

  typedef enum logic [1:0] {
    RespOkay   = 2'b00,
    RespSlvErr = 2'b10
  } resp_e;

  // Read data returned for a request that misses the TLB
  localparam logic [DataWidth-1:0] ErrData = 32'hDEC0FFEE;

  typedef struct packed {
    logic [DataWidth-3:0] pad;
    logic                 read_only;
    logic                 valid;
  } cfg_flags_t;

  // Configuration word, page view for the page registers and flags view otherwise
  typedef union packed {
    logic [DataWidth-1:0] page;
    cfg_flags_t           flags;
  } cfg_word_u;

endpackage

/* design/axi_tlb_l1.sv */
// Fully associative L1 TLB with configuration write port and registered lookup
module axi_tlb_l1 #(
  parameter int unsigned InpAddrWidth = 32,
  parameter int unsigned OupAddrWidth = 32,
  parameter int unsigned NumEntries   = 4
) (
  input  logic                                                   clk_i,
  input  logic                                                   rst_n_i,
  input  logic                                                   cfg_valid_i,
  output logic                                                   cfg_ready_o,
  input  logic [$clog2(NumEntries*tlb_pkg::CfgRegsPerEntry)-1:0] cfg_addr_i,
  input  tlb_pkg::cfg_word_u                                     cfg_wdata_i,
  input  logic                                                   lkp_req_valid_i,
  output logic                                                   lkp_req_ready_o,
  input  logic [InpAddrWidth-1:0]                                lkp_req_addr_i,
  input  logic                                                   lkp_req_write_i,
  output logic                                                   lkp_res_valid_o,
  input  logic                                                   lkp_res_ready_i,
  output logic                                                   lkp_res_hit_o,
  output logic [OupAddrWidth-1:0]                                lkp_res_addr_o
);

  localparam int unsigned CfgAddrWidth  = $clog2(NumEntries * tlb_pkg::CfgRegsPerEntry);
  localparam int unsigned RegIdxWidth   = $clog2(tlb_pkg::CfgRegsPerEntry);
  localparam int unsigned EntryIdxWidth = CfgAddrWidth - RegIdxWidth;
  localparam int unsigned InpPageWidth  = InpAddrWidth - tlb_pkg::PageOffsetWidth;
  localparam int unsigned OupPageWidth  = OupAddrWidth - tlb_pkg::PageOffsetWidth;

  logic [InpPageWidth-1:0]  first_q [NumEntries];
  logic [InpPageWidth-1:0]  last_q  [NumEntries];
  logic [OupPageWidth-1:0]  base_q  [NumEntries];
  logic [NumEntries-1:0]    valid_q;
  logic [NumEntries-1:0]    ro_q;

  logic                     init_q;
  logic                     cfg_we;
  logic [EntryIdxWidth-1:0] cfg_entry;
  logic [RegIdxWidth-1:0]   cfg_reg;

  logic [InpPageWidth-1:0]  inp_page;
  logic                     match;
  logic                     match_ro;
  logic                     hit;
  logic [OupPageWidth-1:0]  oup_page;
  logic                     lkp_req_fire;

  logic                     res_valid_q;
  logic                     res_hit_q;
  logic [OupAddrWidth-1:0]  res_addr_q;

  // Ports stay closed for the first cycle out of reset
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      init_q <= 1'b0;
    end else begin
      init_q <= 1'b1;
    end
  end

  // Config address splits into entry number and register within the entry
  assign cfg_entry   = cfg_addr_i[CfgAddrWidth-1:RegIdxWidth];
  assign cfg_reg     = cfg_addr_i[RegIdxWidth-1:0];
  assign cfg_ready_o = init_q && !res_valid_q;
  assign cfg_we      = cfg_valid_i && cfg_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= '0;
      ro_q    <= '0;
    end else if (cfg_we && cfg_reg == RegIdxWidth'(tlb_pkg::CfgFlagsReg)) begin
      valid_q[cfg_entry] <= cfg_wdata_i.flags.valid;
      ro_q[cfg_entry]    <= cfg_wdata_i.flags.read_only;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cfg_we) begin
      case (cfg_reg)
        RegIdxWidth'(tlb_pkg::CfgFirstReg): first_q[cfg_entry] <= InpPageWidth'(cfg_wdata_i.page);
        RegIdxWidth'(tlb_pkg::CfgLastReg):  last_q[cfg_entry]  <= InpPageWidth'(cfg_wdata_i.page);
        RegIdxWidth'(tlb_pkg::CfgBaseReg):  base_q[cfg_entry]  <= OupPageWidth'(cfg_wdata_i.page);
        default: ;
      endcase
    end
  end

  assign inp_page = lkp_req_addr_i[InpAddrWidth-1:tlb_pkg::PageOffsetWidth];

  // Walk downwards so the lowest matching entry is the one that sticks
  always_comb begin
    match    = 1'b0;
    match_ro = 1'b0;
    oup_page = '0;
    for (int i = NumEntries - 1; i >= 0; i--) begin
      if (valid_q[i] && inp_page >= first_q[i] && inp_page <= last_q[i]) begin
        match    = 1'b1;
        match_ro = ro_q[i];
        oup_page = base_q[i] + OupPageWidth'(inp_page - first_q[i]);
      end
    end
  end

  // Writes into a read-only range are refused
  assign hit = match && !(lkp_req_write_i && match_ro);

  assign lkp_req_ready_o = init_q && (!res_valid_q || lkp_res_ready_i);
  assign lkp_req_fire    = lkp_req_valid_i && lkp_req_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      res_valid_q <= 1'b0;
    end else if (lkp_req_fire) begin
      res_valid_q <= 1'b1;
    end else if (lkp_res_ready_i) begin
      res_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (lkp_req_fire) begin
      res_hit_q  <= hit;
      res_addr_q <= {oup_page, lkp_req_addr_i[tlb_pkg::PageOffsetWidth-1:0]};
    end
  end

  assign lkp_res_valid_o = res_valid_q;
  assign lkp_res_hit_o   = res_hit_q;
  assign lkp_res_addr_o  = res_addr_q;

endmodule

/* design/tlb_route.sv */
// Request router: forks into lookup, joins the result, steers hit or miss, merges responses
module tlb_route #(
  parameter int unsigned InpAddrWidth = 32,
  parameter int unsigned OupAddrWidth = 32,
  parameter int unsigned IdWidth      = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          slv_req_valid_i,
  output logic                          slv_req_ready_o,
  input  logic [InpAddrWidth-1:0]       slv_req_addr_i,
  input  logic [IdWidth-1:0]            slv_req_id_i,
  input  logic                          slv_req_write_i,
  input  logic [tlb_pkg::DataWidth-1:0] slv_req_wdata_i,
  output logic                          slv_rsp_valid_o,
  input  logic                          slv_rsp_ready_i,
  output logic [IdWidth-1:0]            slv_rsp_id_o,
  output logic [tlb_pkg::DataWidth-1:0] slv_rsp_data_o,
  output tlb_pkg::resp_e                slv_rsp_resp_o,
  output logic                          lkp_req_valid_o,
  input  logic                          lkp_req_ready_i,
  output logic [InpAddrWidth-1:0]       lkp_req_addr_o,
  output logic                          lkp_req_write_o,
  input  logic                          lkp_res_valid_i,
  output logic                          lkp_res_ready_o,
  input  logic                          lkp_res_hit_i,
  input  logic [OupAddrWidth-1:0]       lkp_res_addr_i,
  output logic                          mst_req_valid_o,
  input  logic                          mst_req_ready_i,
  output logic [OupAddrWidth-1:0]       mst_req_addr_o,
  output logic [IdWidth-1:0]            mst_req_id_o,
  output logic                          mst_req_write_o,
  output logic [tlb_pkg::DataWidth-1:0] mst_req_wdata_o,
  input  logic                          mst_rsp_valid_i,
  output logic                          mst_rsp_ready_o,
  input  logic [IdWidth-1:0]            mst_rsp_id_i,
  input  logic [tlb_pkg::DataWidth-1:0] mst_rsp_data_i,
  input  tlb_pkg::resp_e                mst_rsp_resp_i,
  output logic                          err_req_valid_o,
  input  logic                          err_req_ready_i,
  output logic [IdWidth-1:0]            err_req_id_o,
  output logic                          err_req_write_o,
  input  logic                          err_rsp_valid_i,
  output logic                          err_rsp_ready_o,
  input  logic [IdWidth-1:0]            err_rsp_id_i,
  input  logic [tlb_pkg::DataWidth-1:0] err_rsp_data_i,
  input  tlb_pkg::resp_e                err_rsp_resp_i
);

  logic                          full_q;
  logic [IdWidth-1:0]            id_q;
  logic                          write_q;
  logic [tlb_pkg::DataWidth-1:0] wdata_q;
  logic                          slv_req_fire;
  logic                          fwd_fire;
  logic                          use_err;
  logic                          lock_q;
  logic                          lock_err_q;

  // Fork: slave transfer and lookup transfer happen together
  assign lkp_req_valid_o = slv_req_valid_i && !full_q;
  assign lkp_req_addr_o  = slv_req_addr_i;
  assign lkp_req_write_o = slv_req_write_i;
  assign slv_req_ready_o = !full_q && lkp_req_ready_i;
  assign slv_req_fire    = slv_req_valid_i && slv_req_ready_o;

  // Join the held payload with the lookup result and steer by hit
  assign mst_req_valid_o = lkp_res_valid_i && lkp_res_hit_i;
  assign mst_req_addr_o  = lkp_res_addr_i;
  assign mst_req_id_o    = id_q;
  assign mst_req_write_o = write_q;
  assign mst_req_wdata_o = wdata_q;
  assign err_req_valid_o = lkp_res_valid_i && !lkp_res_hit_i;
  assign err_req_id_o    = id_q;
  assign err_req_write_o = write_q;

  assign fwd_fire        = (mst_req_valid_o && mst_req_ready_i) ||
                           (err_req_valid_o && err_req_ready_i);
  assign lkp_res_ready_o = fwd_fire;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
    end else if (slv_req_fire) begin
      full_q <= 1'b1;
    end else if (fwd_fire) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (slv_req_fire) begin
      id_q    <= slv_req_id_i;
      write_q <= slv_req_write_i;
      wdata_q <= slv_req_wdata_i;
    end
  end

  // Master response wins, but a stalled response keeps its source
  assign use_err = lock_q ? lock_err_q : !mst_rsp_valid_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      lock_q     <= 1'b0;
      lock_err_q <= 1'b0;
    end else begin
      lock_q     <= slv_rsp_valid_o && !slv_rsp_ready_i;
      lock_err_q <= use_err;
    end
  end

  assign slv_rsp_valid_o = use_err ? err_rsp_valid_i : mst_rsp_valid_i;
  assign slv_rsp_id_o    = use_err ? err_rsp_id_i    : mst_rsp_id_i;
  assign slv_rsp_data_o  = use_err ? err_rsp_data_i  : mst_rsp_data_i;
  assign slv_rsp_resp_o  = use_err ? err_rsp_resp_i  : mst_rsp_resp_i;
  assign mst_rsp_ready_o = !use_err && slv_rsp_ready_i;
  assign err_rsp_ready_o = use_err && slv_rsp_ready_i;

endmodule

/* design/tlb_err_resp.sv */
// Error responder that absorbs missed requests and answers with a slave error
module tlb_err_resp #(
  parameter int unsigned IdWidth = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          err_req_valid_i,
  output logic                          err_req_ready_o,
  input  logic [IdWidth-1:0]            err_req_id_i,
  input  logic                          err_req_write_i,
  output logic                          err_rsp_valid_o,
  input  logic                          err_rsp_ready_i,
  output logic [IdWidth-1:0]            err_rsp_id_o,
  output logic [tlb_pkg::DataWidth-1:0] err_rsp_data_o,
  output tlb_pkg::resp_e                err_rsp_resp_o
);

  logic               valid_q;
  logic [IdWidth-1:0] id_q;
  logic               write_q;
  logic               req_fire;

  // One response slot, refilled in the cycle it drains
  assign err_req_ready_o = !valid_q || err_rsp_ready_i;
  assign req_fire        = err_req_valid_i && err_req_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (req_fire) begin
      valid_q <= 1'b1;
    end else if (err_rsp_ready_i) begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_fire) begin
      id_q    <= err_req_id_i;
      write_q <= err_req_write_i;
    end
  end

  assign err_rsp_valid_o = valid_q;
  assign err_rsp_id_o    = id_q;
  // Writes get zero data back
  assign err_rsp_data_o  = write_q ? '0 : tlb_pkg::ErrData;
  assign err_rsp_resp_o  = tlb_pkg::RespSlvErr;

endmodule

/* design/axi_tlb.sv */
// Address translation unit top level joining L1 TLB, router and error responder
module axi_tlb #(
  parameter int unsigned InpAddrWidth = 32,
  parameter int unsigned OupAddrWidth = 32,
  parameter int unsigned IdWidth      = 4,
  parameter int unsigned NumEntries   = 4
) (
  input  logic                                                   clk_i,
  input  logic                                                   rst_n_i,
  input  logic                                                   slv_req_valid_i,
  output logic                                                   slv_req_ready_o,
  input  logic [InpAddrWidth-1:0]                                slv_req_addr_i,
  input  logic [IdWidth-1:0]                                     slv_req_id_i,
  input  logic                                                   slv_req_write_i,
  input  logic [tlb_pkg::DataWidth-1:0]                          slv_req_wdata_i,
  output logic                                                   slv_rsp_valid_o,
  input  logic                                                   slv_rsp_ready_i,
  output logic [IdWidth-1:0]                                     slv_rsp_id_o,
  output logic [tlb_pkg::DataWidth-1:0]                          slv_rsp_data_o,
  output tlb_pkg::resp_e                                         slv_rsp_resp_o,
  output logic                                                   mst_req_valid_o,
  input  logic                                                   mst_req_ready_i,
  output logic [OupAddrWidth-1:0]                                mst_req_addr_o,
  output logic [IdWidth-1:0]                                     mst_req_id_o,
  output logic                                                   mst_req_write_o,
  output logic [tlb_pkg::DataWidth-1:0]                          mst_req_wdata_o,
  input  logic                                                   mst_rsp_valid_i,
  output logic                                                   mst_rsp_ready_o,
  input  logic [IdWidth-1:0]                                     mst_rsp_id_i,
  input  logic [tlb_pkg::DataWidth-1:0]                          mst_rsp_data_i,
  input  tlb_pkg::resp_e                                         mst_rsp_resp_i,
  input  logic                                                   cfg_valid_i,
  output logic                                                   cfg_ready_o,
  input  logic [$clog2(NumEntries*tlb_pkg::CfgRegsPerEntry)-1:0] cfg_addr_i,
  input  tlb_pkg::cfg_word_u                                     cfg_wdata_i
);

  // Lookup channel between router and L1
  logic                          lkp_req_valid, lkp_req_ready, lkp_req_write;
  logic [InpAddrWidth-1:0]       lkp_req_addr;
  logic                          lkp_res_valid, lkp_res_ready, lkp_res_hit;
  logic [OupAddrWidth-1:0]       lkp_res_addr;

  // Miss channel between router and error responder
  logic                          err_req_valid, err_req_ready, err_req_write;
  logic [IdWidth-1:0]            err_req_id;
  logic                          err_rsp_valid, err_rsp_ready;
  logic [IdWidth-1:0]            err_rsp_id;
  logic [tlb_pkg::DataWidth-1:0] err_rsp_data;
  tlb_pkg::resp_e                err_rsp_resp;

  axi_tlb_l1 #(
    .InpAddrWidth ( InpAddrWidth ),
    .OupAddrWidth ( OupAddrWidth ),
    .NumEntries   ( NumEntries   )
  ) i_l1_tlb (
    .clk_i,
    .rst_n_i,
    .cfg_valid_i,
    .cfg_ready_o,
    .cfg_addr_i,
    .cfg_wdata_i,
    .lkp_req_valid_i ( lkp_req_valid ),
    .lkp_req_ready_o ( lkp_req_ready ),
    .lkp_req_addr_i  ( lkp_req_addr  ),
    .lkp_req_write_i ( lkp_req_write ),
    .lkp_res_valid_o ( lkp_res_valid ),
    .lkp_res_ready_i ( lkp_res_ready ),
    .lkp_res_hit_o   ( lkp_res_hit   ),
    .lkp_res_addr_o  ( lkp_res_addr  )
  );

  tlb_route #(
    .InpAddrWidth ( InpAddrWidth ),
    .OupAddrWidth ( OupAddrWidth ),
    .IdWidth      ( IdWidth      )
  ) i_route (
    .clk_i,
    .rst_n_i,
    .slv_req_valid_i,
    .slv_req_ready_o,
    .slv_req_addr_i,
    .slv_req_id_i,
    .slv_req_write_i,
    .slv_req_wdata_i,
    .slv_rsp_valid_o,
    .slv_rsp_ready_i,
    .slv_rsp_id_o,
    .slv_rsp_data_o,
    .slv_rsp_resp_o,
    .lkp_req_valid_o ( lkp_req_valid ),
    .lkp_req_ready_i ( lkp_req_ready ),
    .lkp_req_addr_o  ( lkp_req_addr  ),
    .lkp_req_write_o ( lkp_req_write ),
    .lkp_res_valid_i ( lkp_res_valid ),
    .lkp_res_ready_o ( lkp_res_ready ),
    .lkp_res_hit_i   ( lkp_res_hit   ),
    .lkp_res_addr_i  ( lkp_res_addr  ),
    .mst_req_valid_o,
    .mst_req_ready_i,
    .mst_req_addr_o,
    .mst_req_id_o,
    .mst_req_write_o,
    .mst_req_wdata_o,
    .mst_rsp_valid_i,
    .mst_rsp_ready_o,
    .mst_rsp_id_i,
    .mst_rsp_data_i,
    .mst_rsp_resp_i,
    .err_req_valid_o ( err_req_valid ),
    .err_req_ready_i ( err_req_ready ),
    .err_req_id_o    ( err_req_id    ),
    .err_req_write_o ( err_req_write ),
    .err_rsp_valid_i ( err_rsp_valid ),
    .err_rsp_ready_o ( err_rsp_ready ),
    .err_rsp_id_i    ( err_rsp_id    ),
    .err_rsp_data_i  ( err_rsp_data  ),
    .err_rsp_resp_i  ( err_rsp_resp  )
  );

  tlb_err_resp #(
    .IdWidth ( IdWidth )
  ) i_err_resp (
    .clk_i,
    .rst_n_i,
    .err_req_valid_i ( err_req_valid ),
    .err_req_ready_o ( err_req_ready ),
    .err_req_id_i    ( err_req_id    ),
    .err_req_write_i ( err_req_write ),
    .err_rsp_valid_o ( err_rsp_valid ),
    .err_rsp_ready_i ( err_rsp_ready ),
    .err_rsp_id_o    ( err_rsp_id    ),
    .err_rsp_data_o  ( err_rsp_data  ),
    .err_rsp_resp_o  ( err_rsp_resp  )
  );

endmodule

/* testbench/axi_tlb_assertions.sv */
// Handshake and reset assertions for the address translation unit, bound to its top level
module axi_tlb_assertions #(
  parameter int unsigned OupAddrWidth = 32,
  parameter int unsigned IdWidth      = 4
) (
  input logic                          clk_i,
  input logic                          rst_n_i,
  input logic                          slv_req_ready_o,
  input logic                          cfg_ready_o,
  input logic                          mst_req_valid_o,
  input logic                          mst_req_ready_i,
  input logic [OupAddrWidth-1:0]       mst_req_addr_o,
  input logic [IdWidth-1:0]            mst_req_id_o,
  input logic                          mst_req_write_o,
  input logic [tlb_pkg::DataWidth-1:0] mst_req_wdata_o,
  input logic                          slv_rsp_valid_o,
  input logic                          slv_rsp_ready_i,
  input logic [IdWidth-1:0]            slv_rsp_id_o,
  input logic [tlb_pkg::DataWidth-1:0] slv_rsp_data_o,
  input tlb_pkg::resp_e                slv_rsp_resp_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // Control outputs stay low in the first cycle out of reset
  a_reset_quiet: assert property (@(posedge clk_i)
    $rose(rst_n_i) |-> !slv_req_ready_o && !cfg_ready_o && !mst_req_valid_o && !slv_rsp_valid_o)
    else $error("control output high in the first cycle after reset");

  a_mst_req_valid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_req_valid_o && !mst_req_ready_i |=> mst_req_valid_o)
    else $error("master request valid dropped while stalled");

  a_mst_req_payload_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    mst_req_valid_o && !mst_req_ready_i |=> $stable(mst_req_addr_o) && $stable(mst_req_id_o)
      && $stable(mst_req_write_o) && $stable(mst_req_wdata_o))
    else $error("master request payload changed while stalled");

  a_slv_rsp_valid_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    slv_rsp_valid_o && !slv_rsp_ready_i |=> slv_rsp_valid_o)
    else $error("slave response valid dropped while stalled");

  a_slv_rsp_payload_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    slv_rsp_valid_o && !slv_rsp_ready_i |=> $stable(slv_rsp_id_o) && $stable(slv_rsp_data_o)
      && $stable(slv_rsp_resp_o))
    else $error("slave response payload changed while stalled");

endmodule

bind axi_tlb axi_tlb_assertions #(
  .OupAddrWidth ( OupAddrWidth ),
  .IdWidth      ( IdWidth      )
) i_assertions (
  .clk_i,
  .rst_n_i,
  .slv_req_ready_o,
  .cfg_ready_o,
  .mst_req_valid_o,
  .mst_req_ready_i,
  .mst_req_addr_o,
  .mst_req_id_o,
  .mst_req_write_o,
  .mst_req_wdata_o,
  .slv_rsp_valid_o,
  .slv_rsp_ready_i,
  .slv_rsp_id_o,
  .slv_rsp_data_o,
  .slv_rsp_resp_o
);

/* testbench/tb_axi_tlb.sv */
// Testbench for the address translation unit, with a memory model on the master port
module tb_axi_tlb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned InpAddrWidth = 32;
  localparam int unsigned OupAddrWidth = 32;
  localparam int unsigned IdWidth      = 4;
  localparam int unsigned NumEntries   = 4;
  localparam int unsigned CfgAddrWidth = $clog2(NumEntries * tlb_pkg::CfgRegsPerEntry);
  localparam int          NumTests     = 14;
  localparam int          ClkPeriod    = 100;
  localparam int          DriveDelay   = 10;
  localparam int          CfgCycles    = 80;
  localparam logic [31:0] Pat          = 32'h5a5a_5a5a;
  localparam logic [31:0] MissData     = 32'hDEC0_FFEE;
  localparam tlb_pkg::resp_e Ok        = tlb_pkg::RespOkay;
  localparam tlb_pkg::resp_e Err       = tlb_pkg::RespSlvErr;

  // One table row; unmap names an entry to invalidate first, or -1
  typedef struct packed {
    logic           write;
    logic [31:0]    addr;
    logic [31:0]    wdata;
    logic           hit;
    logic [31:0]    exp_addr;
    tlb_pkg::resp_e exp_resp;
    logic [31:0]    exp_data;
    int             unmap;
  } vec_t;

  logic clk_i, rst_n_i;
  logic slv_req_valid_i, slv_req_ready_o, slv_req_write_i;
  logic [InpAddrWidth-1:0] slv_req_addr_i;
  logic [IdWidth-1:0] slv_req_id_i, slv_rsp_id_o, mst_req_id_o, mst_rsp_id_i;
  logic [31:0] slv_req_wdata_i, slv_rsp_data_o, mst_req_wdata_o, mst_rsp_data_i;
  logic slv_rsp_valid_o, slv_rsp_ready_i, mst_rsp_valid_i, mst_rsp_ready_o;
  tlb_pkg::resp_e slv_rsp_resp_o, mst_rsp_resp_i;
  logic mst_req_valid_o, mst_req_ready_i, mst_req_write_o;
  logic [OupAddrWidth-1:0] mst_req_addr_o;
  logic cfg_valid_i, cfg_ready_o;
  logic [CfgAddrWidth-1:0] cfg_addr_i;
  tlb_pkg::cfg_word_u cfg_wdata_i;

  vec_t vecs [NumTests];
  logic [31:0] mem [logic [31:0]];
  logic [IdWidth-1:0] rsp_id_q [$];
  logic [31:0] rsp_data_q [$];
  logic [31:0] last_mst_addr;
  int mst_count = 0;
  int rsp_count = 0;
  int errors = 0;
  int passed = 0;
  int failed = 0;

  axi_tlb #(
    .InpAddrWidth ( InpAddrWidth ),
    .OupAddrWidth ( OupAddrWidth ),
    .IdWidth      ( IdWidth      ),
    .NumEntries   ( NumEntries   )
  ) DUT (
    .*
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin : watchdog
    #(ClkPeriod * (NumTests * 50 + CfgCycles));
    $display("ERROR: simulation timed out waiting for the DUT");
    $display("Test failed");
    $finish;
  end

  always @(negedge clk_i) begin
    if (slv_rsp_valid_o && slv_rsp_ready_i) rsp_count++;
  end

  // Master port model, sampled mid-cycle and driven just after the edge
  initial begin : master_model
    logic req_fire;
    logic rsp_fire;
    logic wr;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [IdWidth-1:0] id;
    forever begin
      @(negedge clk_i);
      req_fire = mst_req_valid_o && mst_req_ready_i;
      rsp_fire = mst_rsp_valid_i && mst_rsp_ready_o;
      wr       = mst_req_write_o;
      addr     = mst_req_addr_o;
      wdata    = mst_req_wdata_o;
      id       = mst_req_id_o;
      @(posedge clk_i);
      #DriveDelay;
      if (rsp_fire) begin
        void'(rsp_id_q.pop_front());
        void'(rsp_data_q.pop_front());
      end
      if (req_fire) begin
        mst_count++;
        last_mst_addr = addr;
        rsp_id_q.push_back(id);
        if (wr) begin
          mem[addr] = wdata;
          rsp_data_q.push_back(32'h0);
        end else begin
          rsp_data_q.push_back(mem.exists(addr) ? mem[addr] : addr ^ Pat);
        end
      end
      mst_rsp_valid_i = (rsp_id_q.size() != 0);
      mst_rsp_id_i    = mst_rsp_valid_i ? rsp_id_q[0] : '0;
      mst_rsp_data_i  = mst_rsp_valid_i ? rsp_data_q[0] : '0;
      mst_req_ready_i = ($urandom_range(3) != 0);
    end
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic cfg_write(input int idx, input tlb_pkg::cfg_word_u w);
    logic done;
    cfg_valid_i = 1'b1;
    cfg_addr_i  = CfgAddrWidth'(idx);
    cfg_wdata_i = w;
    done = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      done = cfg_ready_o;
      @(posedge clk_i);
      #DriveDelay;
    end
    cfg_valid_i = 1'b0;
  endtask

  task automatic program_entry(input int e, input logic [19:0] first, input logic [19:0] last,
                               input logic [19:0] base, input logic ro);
    tlb_pkg::cfg_word_u w;
    int blk;
    blk = e * tlb_pkg::CfgRegsPerEntry;
    w = '0;
    w.page = 32'(first);
    cfg_write(blk + tlb_pkg::CfgFirstReg, w);
    w.page = 32'(last);
    cfg_write(blk + tlb_pkg::CfgLastReg, w);
    w.page = 32'(base);
    cfg_write(blk + tlb_pkg::CfgBaseReg, w);
    w = '0;
    w.flags.valid     = 1'b1;
    w.flags.read_only = ro;
    cfg_write(blk + tlb_pkg::CfgFlagsReg, w);
  endtask

  task automatic unmap_entry(input int e);
    tlb_pkg::cfg_word_u w;
    w = '0;
    cfg_write(e * tlb_pkg::CfgRegsPerEntry + tlb_pkg::CfgFlagsReg, w);
  endtask

  task automatic load_table();
    // Entry 0 wins over entry 1 on pages 0x18..0x1f
    vecs[0]  = '{1'b0, 32'h0001_2345, 32'h0, 1'b1, 32'h8000_2345, Ok, 32'h8000_2345 ^ Pat, -1};
    vecs[1]  = '{1'b1, 32'h0001_2400, 32'h1234_5678, 1'b1, 32'h8000_2400, Ok, 32'h0, -1};
    vecs[2]  = '{1'b0, 32'h0001_2400, 32'h0, 1'b1, 32'h8000_2400, Ok, 32'h1234_5678, -1};
    vecs[3]  = '{1'b0, 32'h0003_0000, 32'h0, 1'b0, 32'h0, Err, MissData, -1};
    vecs[4]  = '{1'b1, 32'h0005_0000, 32'h5555_aaaa, 1'b0, 32'h0, Err, 32'h0, -1};
    vecs[5]  = '{1'b1, 32'h0004_1ffc, 32'h0bad_0bad, 1'b0, 32'h0, Err, 32'h0, -1};
    vecs[6]  = '{1'b0, 32'h0004_1ffc, 32'h0, 1'b1, 32'ha001_1ffc, Ok, 32'ha001_1ffc ^ Pat, -1};
    vecs[7]  = '{1'b0, 32'h0001_8abc, 32'h0, 1'b1, 32'h8000_8abc, Ok, 32'h8000_8abc ^ Pat, -1};
    vecs[8]  = '{1'b0, 32'h0002_0010, 32'h0, 1'b1, 32'h9000_8010, Ok, 32'h9000_8010 ^ Pat, -1};
    vecs[9]  = '{1'b0, 32'h0010_0004, 32'h0, 1'b1, 32'hc000_0004, Ok, 32'hc000_0004 ^ Pat, -1};
    vecs[10] = '{1'b0, 32'h0010_0004, 32'h0, 1'b0, 32'h0, Err, MissData, 3};
    vecs[11] = '{1'b1, 32'h0002_7ff0, 32'hcafe_f00d, 1'b1, 32'h9000_fff0, Ok, 32'h0, -1};
    vecs[12] = '{1'b0, 32'h0002_7ff0, 32'h0, 1'b1, 32'h9000_fff0, Ok, 32'hcafe_f00d, -1};
    vecs[13] = '{1'b0, 32'h0000_f000, 32'h0, 1'b0, 32'h0, Err, MissData, -1};
  endtask

  task automatic run_test(input int t);
    vec_t v;
    logic done;
    int mst_before;
    int errs_before;
    logic [IdWidth-1:0] id;
    logic [IdWidth-1:0] rsp_id;
    logic [31:0] rsp_data;
    tlb_pkg::resp_e rsp_resp;
    v = vecs[t];
    id = IdWidth'(t);
    errs_before = errors;
    if (v.unmap >= 0) unmap_entry(v.unmap);
    mst_before = mst_count;
    slv_req_valid_i = 1'b1;
    slv_req_addr_i  = v.addr;
    slv_req_id_i    = id;
    slv_req_write_i = v.write;
    slv_req_wdata_i = v.wdata;
    done = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      done = slv_req_ready_o;
      @(posedge clk_i);
      #DriveDelay;
      slv_rsp_ready_i = ($urandom_range(3) != 0);
    end
    slv_req_valid_i = 1'b0;
    done = 1'b0;
    while (!done) begin
      @(negedge clk_i);
      if (slv_rsp_valid_o && slv_rsp_ready_i) begin
        done     = 1'b1;
        rsp_id   = slv_rsp_id_o;
        rsp_data = slv_rsp_data_o;
        rsp_resp = slv_rsp_resp_o;
      end
      @(posedge clk_i);
      #DriveDelay;
      slv_rsp_ready_i = ($urandom_range(3) != 0);
    end
    check_value("response id", 32'(rsp_id), 32'(id));
    check_value("response code", 32'(rsp_resp), 32'(v.exp_resp));
    check_value("response data", rsp_data, v.exp_data);
    check_value("master request count", 32'(mst_count - mst_before), v.hit ? 32'd1 : 32'd0);
    if (v.hit) check_value("master address", last_mst_addr, v.exp_addr);
    if (errors == errs_before) passed++;
    else failed++;
    $display("test %2d %s addr=%h resp=%0d data=%h %s", t, v.write ? "write" : "read ",
             v.addr, rsp_resp, rsp_data, (errors == errs_before) ? "ok" : "FAILED");
  endtask

  initial begin : stimulus
    void'($urandom(32'h3bfb_fd32));
    rst_n_i = 1'b0;
    slv_req_valid_i = 1'b0;
    slv_req_addr_i  = '0;
    slv_req_id_i    = '0;
    slv_req_write_i = 1'b0;
    slv_req_wdata_i = '0;
    slv_rsp_ready_i = 1'b0;
    mst_req_ready_i = 1'b0;
    mst_rsp_valid_i = 1'b0;
    mst_rsp_id_i    = '0;
    mst_rsp_data_i  = '0;
    mst_rsp_resp_i  = tlb_pkg::RespOkay;
    cfg_valid_i     = 1'b0;
    cfg_addr_i      = '0;
    cfg_wdata_i     = '0;
    repeat (2) @(posedge clk_i);
    #DriveDelay;
    rst_n_i = 1'b1;
    program_entry(0, 20'h00010, 20'h0001f, 20'h80000, 1'b0);
    program_entry(1, 20'h00018, 20'h00027, 20'h90000, 1'b0);
    program_entry(2, 20'h00040, 20'h00043, 20'ha0010, 1'b1);
    program_entry(3, 20'h00100, 20'h00100, 20'hc0000, 1'b0);
    load_table();
    for (int t = 0; t < NumTests; t++) run_test(t);
    // Let any stray response show up before counting
    repeat (10) @(posedge clk_i);
    check_value("total responses", 32'(rsp_count), 32'(NumTests));
    $display("tests %0d, passed %0d, failed %0d, mismatches %0d",
             NumTests, passed, failed, errors);
    if (failed == 0 && errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* all.f */
design/tlb_pkg.sv
design/axi_tlb_l1.sv
design/tlb_route.sv
design/tlb_err_resp.sv
design/axi_tlb.sv
testbench/axi_tlb_assertions.sv
testbench/tb_axi_tlb.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it and search the log for the pass line

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_axi_tlb -f all.f -Mdir "$BUILD_DIR" -o tb_axi_tlb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

"./$BUILD_DIR/tb_axi_tlb" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "Test completed successfully" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL: pass line not found in $LOG"
  exit 1
fi
